//--- rtl/ingress_pkg.sv
// Router ingress shared definitions

package ingress_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes

    // Physical ingress ports and their index width
    localparam int NUM_PORTS      = 4;
    localparam int PORT_IDX_WIDTH = 2;

    // Beat geometry, same on every port and on the converged bus
    localparam int DATA_BYTES = 4;
    localparam int DATA_WIDTH = DATA_BYTES * 8;

    // Per-port packet store
    localparam int BUF_DEPTH      = 64;
    localparam int BUF_ADDR_WIDTH = 6;
    localparam int MAX_PKT_WORDS  = 32;

    localparam int COUNTER_WIDTH = 32;

    ////////////////////////////////////////////////////////////////////////////
    // Beat and counter types

    // One beat from a physical port
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [DATA_BYTES-1:0] keep;
        logic                  last;
    } ingress_beat_t;

    // Converged bus beat, tagged with the port it came from
    typedef struct packed {
        logic [DATA_WIDTH-1:0]     data;
        logic [DATA_BYTES-1:0]     keep;
        logic                      last;
        logic [PORT_IDX_WIDTH-1:0] ingress_port;
    } bus_beat_t;

    typedef logic [COUNTER_WIDTH-1:0] pkt_count_t;

endpackage

//--- rtl/ingress_port_buffer.sv
// Ingress port packet buffer
`timescale 1ns/10ps

module ingress_port_buffer import ingress_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          port_enable,
    input  logic          in_valid,
    input  ingress_beat_t in_beat,
    input  logic          pop,
    output logic          pkt_avail,
    output ingress_beat_t head_beat,
    output logic          pkt_commit,
    output logic          buf_overflow
);

    // Packet store
    ingress_beat_t mem [BUF_DEPTH-1:0];

    // Pointers carry one extra bit so a full store differs from an empty one
    logic [BUF_ADDR_WIDTH:0] wr_ptr;
    logic [BUF_ADDR_WIDTH:0] commit_ptr;
    logic [BUF_ADDR_WIDTH:0] rd_ptr;
    logic [BUF_ADDR_WIDTH:0] fill;

    // Number of whole packets ready for the arbiter
    logic [BUF_ADDR_WIDTH:0] pkt_cnt;

    logic in_pkt;
    logic discard;
    logic first_beat;
    logic drop_beat;
    logic buf_full;
    logic take_beat;
    logic overflow_now;
    logic commit_now;
    logic pop_last;

    ////////////////////////////////////////////////////////////////////////////
    // Write side decisions

    assign first_beat = in_valid && !in_pkt;

    // Disabled port at packet start drops the whole packet quietly
    assign drop_beat = discard || (first_beat && !port_enable);

    // Fill never exceeds the depth, so the top bit alone marks full
    assign fill     = wr_ptr - rd_ptr;
    assign buf_full = fill[BUF_ADDR_WIDTH];

    assign take_beat    = in_valid && !drop_beat && !buf_full;
    assign overflow_now = in_valid && !drop_beat && buf_full;
    assign commit_now   = take_beat && in_beat.last;

    always_ff @(posedge clk) begin
        if (take_beat) begin
            mem[wr_ptr[BUF_ADDR_WIDTH-1:0]] <= in_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            in_pkt       <= 1'b0;
            discard      <= 1'b0;
            wr_ptr       <= '0;
            commit_ptr   <= '0;
            pkt_commit   <= 1'b0;
            buf_overflow <= 1'b0;
        end else begin
            pkt_commit   <= commit_now;
            buf_overflow <= overflow_now;

            if (in_valid) begin
                in_pkt <= !in_beat.last;
            end

            // Rest of the packet is skipped after a drop, up to its last beat
            if (in_valid && in_beat.last) begin
                discard <= 1'b0;
            end else if (overflow_now || (first_beat && !port_enable)) begin
                discard <= 1'b1;
            end

            // Overflow throws away the partial packet written so far
            if (overflow_now) begin
                wr_ptr <= commit_ptr;
            end else if (take_beat) begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            if (commit_now) begin
                commit_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read side

    assign head_beat = mem[rd_ptr[BUF_ADDR_WIDTH-1:0]];
    assign pop_last  = pop && head_beat.last;
    assign pkt_avail = (pkt_cnt != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr  <= '0;
            pkt_cnt <= '0;
        end else begin
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Commit and a popped tail can land in the same cycle
            if (commit_now && !pop_last) begin
                pkt_cnt <= pkt_cnt + 1'b1;
            end else if (pop_last && !commit_now) begin
                pkt_cnt <= pkt_cnt - 1'b1;
            end
        end
    end

endmodule

//--- rtl/ingress_arbiter.sv
// Packet round-robin merge onto the converged bus
`timescale 1ns/10ps

module ingress_arbiter import ingress_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [NUM_PORTS-1:0] pkt_avail,
    input  ingress_beat_t        head_beat [NUM_PORTS-1:0],
    output logic [NUM_PORTS-1:0] pop,
    output logic                 out_valid,
    input  logic                 out_ready,
    output bus_beat_t            out_beat,
    output logic                 bus_pkt_done
);

    logic [PORT_IDX_WIDTH-1:0] rr_ptr;
    logic [PORT_IDX_WIDTH-1:0] grant;
    logic                      busy;
    logic                      tail_popped;

    logic [PORT_IDX_WIDTH-1:0] next_port;
    logic                      next_found;
    logic                      slot_free;
    logic                      pop_any;
    ingress_beat_t             grant_beat;

    ////////////////////////////////////////////////////////////////////////////
    // Next port search, starting at the round-robin pointer

    always_comb begin
        logic [PORT_IDX_WIDTH-1:0] idx;
        next_port  = rr_ptr;
        next_found = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            idx = rr_ptr + PORT_IDX_WIDTH'(i);
            if (!next_found && pkt_avail[idx]) begin
                next_port  = idx;
                next_found = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Grant, held for the whole packet

    assign grant_beat = head_beat[grant];

    // Output register can take a beat when empty or draining this cycle
    assign slot_free = !out_valid || out_ready;
    assign pop_any   = busy && !tail_popped && slot_free;

    always_comb begin
        pop = '0;
        if (pop_any) begin
            pop[grant] = 1'b1;
        end
    end

    assign bus_pkt_done = out_valid && out_ready && out_beat.last;

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr      <= '0;
            grant       <= '0;
            busy        <= 1'b0;
            tail_popped <= 1'b0;
        end else begin
            if (!busy) begin
                if (next_found) begin
                    busy        <= 1'b1;
                    grant       <= next_port;
                    rr_ptr      <= next_port + 1'b1;
                    tail_popped <= 1'b0;
                end
            end else begin
                if (pop_any && grant_beat.last) begin
                    tail_popped <= 1'b1;
                end
                // Release only once the tail has left the bus
                if (bus_pkt_done) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (pop_any) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_any) begin
            out_beat.data         <= grant_beat.data;
            out_beat.keep         <= grant_beat.keep;
            out_beat.last         <= grant_beat.last;
            out_beat.ingress_port <= grant;
        end
    end

endmodule

//--- rtl/ingress_counters.sv
// Packet counters for the ports and the converged bus
`timescale 1ns/10ps

module ingress_counters import ingress_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [NUM_PORTS-1:0] pkt_commit,
    input  logic [NUM_PORTS-1:0] port_cnt_clear,
    input  logic                 bus_pkt_done,
    input  logic                 bus_cnt_clear,
    output pkt_count_t           port_pkt_cnt [NUM_PORTS-1:0],
    output pkt_count_t           bus_pkt_cnt
);

    // Slots 0 to NUM_PORTS-1 are the ports, the top slot is the bus
    pkt_count_t           cnt     [NUM_PORTS:0];
    logic [NUM_PORTS:0]   cnt_inc;
    logic [NUM_PORTS:0]   cnt_clr;

    assign cnt_inc = {bus_pkt_done, pkt_commit};
    assign cnt_clr = {bus_cnt_clear, port_cnt_clear};

    ////////////////////////////////////////////////////////////////////////////
    // Count update, clear has priority

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i <= NUM_PORTS; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i <= NUM_PORTS; i++) begin
                if (cnt_clr[i]) begin
                    cnt[i] <= '0;
                end else if (cnt_inc[i]) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    generate
        for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port_cnt
            assign port_pkt_cnt[p] = cnt[p];
        end
    endgenerate

    assign bus_pkt_cnt = cnt[NUM_PORTS];

endmodule

//--- rtl/router_ingress.sv
// Router ingress aggregator
`timescale 1ns/10ps

module router_ingress import ingress_pkg::*; (
    // Core clock and packet sink reset
    input  logic                 clk,
    input  logic                 reset,

    // Physical ingress ports
    input  logic [NUM_PORTS-1:0] port_enable,
    input  logic [NUM_PORTS-1:0] in_valid,
    input  ingress_beat_t        in_beat [NUM_PORTS-1:0],

    // Converged bus
    output logic                 out_valid,
    input  logic                 out_ready,
    output bus_beat_t            out_beat,

    // Status and counters
    output pkt_count_t           port_pkt_cnt [NUM_PORTS-1:0],
    input  logic [NUM_PORTS-1:0] port_cnt_clear,
    output pkt_count_t           bus_pkt_cnt,
    input  logic                 bus_cnt_clear,
    output logic [NUM_PORTS-1:0] buf_overflow
);

    logic [NUM_PORTS-1:0] pkt_avail;
    logic [NUM_PORTS-1:0] pop;
    logic [NUM_PORTS-1:0] pkt_commit;
    ingress_beat_t        head_beat [NUM_PORTS-1:0];
    logic                 bus_pkt_done;

    ////////////////////////////////////////////////////////////////////////////
    // One packet buffer per physical port

    generate
        for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
            ingress_port_buffer ingress_port_buffer_inst (
                .clk          (clk),
                .reset        (reset),
                .port_enable  (port_enable[p]),
                .in_valid     (in_valid[p]),
                .in_beat      (in_beat[p]),
                .pop          (pop[p]),
                .pkt_avail    (pkt_avail[p]),
                .head_beat    (head_beat[p]),
                .pkt_commit   (pkt_commit[p]),
                .buf_overflow (buf_overflow[p])
            );
        end
    endgenerate

    ingress_arbiter ingress_arbiter_inst (
        .clk          (clk),
        .reset        (reset),
        .pkt_avail    (pkt_avail),
        .head_beat    (head_beat),
        .pop          (pop),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_beat     (out_beat),
        .bus_pkt_done (bus_pkt_done)
    );

    ingress_counters ingress_counters_inst (
        .clk            (clk),
        .reset          (reset),
        .pkt_commit     (pkt_commit),
        .port_cnt_clear (port_cnt_clear),
        .bus_pkt_done   (bus_pkt_done),
        .bus_cnt_clear  (bus_cnt_clear),
        .port_pkt_cnt   (port_pkt_cnt),
        .bus_pkt_cnt    (bus_pkt_cnt)
    );

endmodule

//--- tests/ingress_tb_checks.svh
// Reference model and compare tasks
`ifndef INGRESS_TB_CHECKS_SVH
`define INGRESS_TB_CHECKS_SVH

////////////////////////////////////////////////////////////////////////////
// Reference model

// A kept beat leaves the bus unchanged and tagged with its ingress port
function automatic bus_beat_t expected_beat(ingress_beat_t beat, int port);
    bus_beat_t exp_beat;
    exp_beat.data         = beat.data;
    exp_beat.keep         = beat.keep;
    exp_beat.last         = beat.last;
    exp_beat.ingress_port = PORT_IDX_WIDTH'(port);
    return exp_beat;
endfunction

////////////////////////////////////////////////////////////////////////////
// Compare tasks

task automatic check_beat(string name, bus_beat_t got, bus_beat_t exp_beat);
    if (got !== exp_beat) begin
        $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp_beat);
        stop_on_error();
    end
endtask

task automatic check_count(string name, pkt_count_t got, pkt_count_t exp_cnt);
    if (got !== exp_cnt) begin
        $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp_cnt);
        stop_on_error();
    end
endtask

`endif

//--- tests/router_ingress_tb.sv
// Router ingress aggregator testbench
`timescale 1ns/10ps

module router_ingress_tb import ingress_pkg::*; ();

    localparam int PKTS_PER_BURST = 2;
    localparam int TEST_SLACK     = 200;

    logic                 core_clk_ifc;
    logic                 packet_sink_reset;
    logic [NUM_PORTS-1:0] port_enable;
    logic [NUM_PORTS-1:0] in_valid;
    ingress_beat_t        in_beat [NUM_PORTS-1:0];
    logic                 out_valid;
    logic                 out_ready;
    bus_beat_t            out_beat;
    pkt_count_t           port_pkt_cnt [NUM_PORTS-1:0];
    logic [NUM_PORTS-1:0] port_cnt_clear;
    pkt_count_t           bus_pkt_cnt;
    logic                 bus_cnt_clear;
    logic [NUM_PORTS-1:0] buf_overflow;

    integer seed = 32'hf5e2_16df;

    // Per-port beats still to drive and beats still expected on the bus
    ingress_beat_t stim_q [NUM_PORTS][$];
    bus_beat_t     exp_q  [NUM_PORTS][$];
    int            sent_pkts [NUM_PORTS];

    // Reset cycles count toward the budget too
    int cycle_cnt   = 0;
    int cycle_limit = 4 * 4;

    int                        ready_mode  = 0;  // 0 high, 1 random, 2 low
    bit                        skip_ok     = 1'b0;
    bit                        ovf_ok      = 1'b0;
    bit                        mid_pkt     = 1'b0;
    logic [PORT_IDX_WIDTH-1:0] cur_port    = '0;
    logic [NUM_PORTS-1:0]      enable_mask = '0;
    logic [NUM_PORTS-1:0]      ovf_seen    = '0;

    `include "ingress_tb_checks.svh"

    router_ingress router_ingress_inst (
        .clk            (core_clk_ifc),
        .reset          (packet_sink_reset),
        .port_enable    (port_enable),
        .in_valid       (in_valid),
        .in_beat        (in_beat),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_beat       (out_beat),
        .port_pkt_cnt   (port_pkt_cnt),
        .port_cnt_clear (port_cnt_clear),
        .bus_pkt_cnt    (bus_pkt_cnt),
        .bus_cnt_clear  (bus_cnt_clear),
        .buf_overflow   (buf_overflow)
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #50 core_clk_ifc = ~core_clk_ifc;
    end

    // Cycle budget and the out_ready pattern
    always @(posedge core_clk_ifc) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            stop_on_error();
        end else begin
            case (ready_mode)
                0:       out_ready <= 1'b1;
                1:       out_ready <= 1'($random(seed));
                default: out_ready <= 1'b0;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Every bus transfer is compared mid-cycle

    always @(negedge core_clk_ifc) begin
        int p;
        ovf_seen = ovf_seen | buf_overflow;
        if (buf_overflow != '0 && !ovf_ok) begin
            $display("ERROR: buf_overflow got 0x%h expected 0x0", buf_overflow);
            stop_on_error();
        end else if (out_valid && out_ready) begin
            p = int'(out_beat.ingress_port);
            if (skip_ok && !mid_pkt) begin
                skip_dropped(p, out_beat);
            end
            if ($isunknown(out_beat.ingress_port)) begin
                $display("Bus beat carries an unknown ingress port tag");
                stop_on_error();
            end else if (mid_pkt && out_beat.ingress_port != cur_port) begin
                $display("Bus switched from port %0d to port %0d inside a packet", cur_port, p);
                stop_on_error();
            end else if (exp_q[p].size() == 0) begin
                $display("Unexpected packet on the bus from port %0d", p);
                stop_on_error();
            end else begin
                check_beat("out_beat", out_beat, exp_q[p].pop_front());
                mid_pkt  = !out_beat.last;
                cur_port = out_beat.ingress_port;
            end
        end
    end

    // Packets dropped on overflow are removed whole from the queue head
    task automatic skip_dropped(int port, bus_beat_t beat);
        bus_beat_t skipped;
        while (exp_q[port].size() > 0 && exp_q[port][0] != beat) begin
            skipped = exp_q[port].pop_front();
            while (!skipped.last) begin
                skipped = exp_q[port].pop_front();
            end
        end
    endtask

    task automatic stop_on_error();
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopped at the first error");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    task automatic queue_packet(int port, bit kept);
        ingress_beat_t beat;
        int            len;
        len = 1 + ($unsigned($random(seed)) % MAX_PKT_WORDS);
        cycle_limit += len * 4;
        for (int i = 0; i < len; i++) begin
            beat.data = $random(seed);
            beat.last = (i == len - 1);
            beat.keep = beat.last ? (4'($random(seed)) | 4'h1) : 4'hf;
            stim_q[port].push_back(beat);
            if (kept) begin
                exp_q[port].push_back(expected_beat(beat, port));
            end
        end
        if (kept) begin
            sent_pkts[port]++;
        end
    endtask

    task automatic queue_burst(int pkts);
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int k = 0; k < pkts; k++) begin
                queue_packet(p, enable_mask[p]);
            end
        end
    endtask

    // All ports stream in parallel with one beat per cycle each
    task automatic drive_stimulus();
        bit pending;
        pending = 1'b1;
        while (pending) begin
            @(posedge core_clk_ifc);
            pending = 1'b0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (stim_q[p].size() > 0) begin
                    in_valid[p] <= 1'b1;
                    in_beat[p]  <= stim_q[p].pop_front();
                    pending = 1'b1;
                end else begin
                    in_valid[p] <= 1'b0;
                end
            end
        end
    endtask

    // Queues only change mid-cycle, so they are read on the rising edge
    task automatic wait_drain();
        bit busy;
        busy = 1'b1;
        while (busy) begin
            @(posedge core_clk_ifc);
            busy = 1'b0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (exp_q[p].size() != 0) begin
                    busy = 1'b1;
                end
            end
        end
        @(negedge core_clk_ifc);
    endtask

    // Done once every committed packet has left the bus
    task automatic wait_bus_idle();
        pkt_count_t total;
        do begin
            @(negedge core_clk_ifc);
            total = '0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                total += port_pkt_cnt[p];
            end
        end while (bus_pkt_cnt != total);
    endtask

    task automatic run_burst(int pkts);
        queue_burst(pkts);
        drive_stimulus();
        wait_drain();
    endtask

    task automatic clear_counters();
        @(posedge core_clk_ifc);
        port_cnt_clear <= '1;
        bus_cnt_clear  <= 1'b1;
        @(posedge core_clk_ifc);
        port_cnt_clear <= '0;
        bus_cnt_clear  <= 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            sent_pkts[p] = 0;
        end
    endtask

    task automatic check_counters();
        int total;
        total = 0;
        @(negedge core_clk_ifc);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_count($sformatf("port_pkt_cnt[%0d]", p), port_pkt_cnt[p],
                        pkt_count_t'(sent_pkts[p]));
            total += sent_pkts[p];
        end
        check_count("bus_pkt_cnt", bus_pkt_cnt, pkt_count_t'(total));
    endtask

    task automatic start_test(string name, logic [NUM_PORTS-1:0] mask);
        $display("Test: %s", name);
        cycle_limit += TEST_SLACK * 4;
        enable_mask = mask;
        @(posedge core_clk_ifc);
        port_enable <= mask;
        clear_counters();
        @(negedge core_clk_ifc);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        packet_sink_reset = 1'b1;
        port_enable       = '0;
        in_valid          = '0;
        in_beat           = '{default: '0};
        out_ready         = 1'b0;
        port_cnt_clear    = '0;
        bus_cnt_clear     = 1'b0;
        repeat (4) @(posedge core_clk_ifc);
        packet_sink_reset <= 1'b0;

        start_test("all ports enabled, bus always ready", '1);
        repeat (2) run_burst(PKTS_PER_BURST);
        check_counters();

        start_test("all ports disabled", '0);
        queue_burst(PKTS_PER_BURST);
        drive_stimulus();
        repeat (8) @(posedge core_clk_ifc);
        check_counters();

        start_test("port 0 disabled", 4'b1110);
        repeat (2) run_burst(PKTS_PER_BURST);
        check_counters();

        start_test("random back-pressure", '1);
        ready_mode = 1;
        repeat (3) run_burst(PKTS_PER_BURST);
        check_counters();

        // Stall the bus until every buffer has dropped a packet
        start_test("overflow under back-pressure", '1);
        ready_mode = 2;
        skip_ok    = 1'b1;
        ovf_ok     = 1'b1;
        ovf_seen   = '0;
        for (int b = 0; b < 2 * BUF_DEPTH && ovf_seen != '1; b++) begin
            queue_burst(1);
            drive_stimulus();
            @(posedge core_clk_ifc);
        end
        if (ovf_seen != '1) begin
            $display("buf_overflow never pulsed on every port under back-pressure");
            stop_on_error();
        end
        ready_mode = 0;
        wait_bus_idle();
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_q[p].delete();
        end
        skip_ok = 1'b0;
        ovf_ok  = 1'b0;
        clear_counters();
        check_counters();
        run_burst(1);
        check_counters();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+tests
rtl/ingress_pkg.sv
rtl/ingress_port_buffer.sv
rtl/ingress_arbiter.sv
rtl/ingress_counters.sv
rtl/router_ingress.sv
tests/router_ingress_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 -Wno-fatal
TOP       = router_ingress_tb
FILELIST  = verilog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
